/* filelist.f */
+incdir+verilog
verilog/conv2d_pkg.sv
verilog/conv2d_inst_reg.sv
verilog/conv2d_ctrl.sv
verilog/conv2d_matrix_loader.sv
verilog/conv2d_mac_core.sv
verilog/conv2d_output_store.sv
verilog/conv2d_top.sv
sim/conv2d_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the conv2d testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module conv2d_tb -f filelist.f -o conv2d_sim

./obj_dir/conv2d_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* sim/conv2d_tb.sv */
`include "conv2d_defines.svh"

module conv2d_tb
  import conv2d_pkg::*;
();

  localparam int CYCLES_PER_TEST = 400;
  localparam int SW = `CONV_SCALAR_W;
  localparam int AW = `CONV_ACC_W;

  logic        clk;
  logic        rstnn;
  logic        i_inst_valid;
  conv_inst_t  i_inst;
  logic        o_inst_ready;
  logic        i_img_valid;
  logic        i_img_last;
  img_row_t    i_img_row;
  logic        o_img_ready;
  logic        i_ker_valid;
  logic        i_ker_last;
  ker_row_t    i_ker_row;
  logic        o_ker_ready;
  logic        o_out_valid;
  logic        o_out_last;
  out_row_t    o_out_row;
  logic        i_out_ready;
  logic        o_done;

  // Rows of all tests back to back with a base index per test
  conv_inst_t  inst_q[$];
  img_row_t    img_q[$];
  ker_row_t    ker_q[$];
  out_row_t    exp_q[$];
  int          img_base[$];
  int          ker_base[$];
  int          exp_base[$];
  int          out_rows_q[$];

  int          n_tests;
  logic        tests_loaded;
  int          value_errs;
  int          proto_errs;
  int          rows_checked;
  int          done_count;
  logic        op_active;   // Between instruction handshake and o_done
  logic [31:0] rng;

  conv2d_top u_conv2d_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng;
  endfunction

  //////////////////////////////////////////////////
  // Tests file
  //////////////////////////////////////////////////

  task automatic load_tests();
    int          fd;
    int          n;
    string       hdr;
    logic [31:0] irm1;
    logic [31:0] icm1;
    logic [31:0] krm1;
    logic [31:0] kcm1;
    logic [31:0] sm1;
    logic [31:0] v;
    conv_inst_t  inst;
    img_row_t    img_row;
    ker_row_t    ker_row;
    out_row_t    exp_row;
    int          orows;
    int          ocols;
    fd = $fopen("sim/conv2d_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the tests file sim/conv2d_tests.txt");
      proto_errs++;
      return;
    end
    n = $fgets(hdr, fd);  // Column notes
    n = $fgets(hdr, fd);
    while ($fscanf(fd, "%h %h %h %h %h", irm1, icm1, krm1, kcm1, sm1) == 5)
    begin
      inst = '{img_rows_m1: dim_t'(irm1), img_cols_m1: dim_t'(icm1),
               ker_rows_m1: dim_t'(krm1), ker_cols_m1: dim_t'(kcm1), stride_m1: sm1[0]};
      // floor((image - kernel) / stride) + 1
      orows = (int'(irm1) - int'(krm1)) / (int'(sm1) + 1) + 1;
      ocols = (int'(icm1) - int'(kcm1)) / (int'(sm1) + 1) + 1;
      inst_q.push_back(inst);
      out_rows_q.push_back(orows);
      img_base.push_back(img_q.size());
      ker_base.push_back(ker_q.size());
      exp_base.push_back(exp_q.size());
      for (int r = 0; r <= int'(irm1); r++)
      begin
        img_row = '0;
        for (int c = 0; c <= int'(icm1); c++)
        begin
          n = $fscanf(fd, "%h", v);
          img_row[c*SW +: SW] = v[SW-1:0];
        end
        img_q.push_back(img_row);
      end
      for (int r = 0; r <= int'(krm1); r++)
      begin
        ker_row = '0;
        for (int c = 0; c <= int'(kcm1); c++)
        begin
          n = $fscanf(fd, "%h", v);
          ker_row[c*SW +: SW] = v[SW-1:0];
        end
        ker_q.push_back(ker_row);
      end
      for (int r = 0; r < orows; r++)
      begin
        exp_row = '0;   // Columns past the output width are zero
        for (int c = 0; c < ocols; c++)
        begin
          n = $fscanf(fd, "%h", v);
          exp_row[c*AW +: AW] = v[AW-1:0];
        end
        exp_q.push_back(exp_row);
      end
      if (n != 1)
      begin
        $display("the tests file ended in the middle of test %0d", inst_q.size() - 1);
        proto_errs++;
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // Stream drivers
  //////////////////////////////////////////////////

  task automatic send_instruction(int t);
    @(posedge clk);
    i_inst_valid <= 1'b1;
    i_inst       <= inst_q[t];
    @(negedge clk);
    while (!o_inst_ready)
      @(negedge clk);
    @(posedge clk);
    i_inst_valid <= 1'b0;
  endtask

  // Image or kernel rows with random valid gaps
  task automatic load_matrix(int t, bit kernel);
    int rows;
    int base;
    rows = kernel ? int'(inst_q[t].ker_rows_m1) + 1 : int'(inst_q[t].img_rows_m1) + 1;
    base = kernel ? ker_base[t] : img_base[t];
    for (int r = 0; r < rows; r++)
    begin
      while (((next_random() >> 16) % 4) == 0)
      begin
        i_img_valid <= 1'b0;
        i_ker_valid <= 1'b0;
        @(posedge clk);
      end
      if (kernel)
      begin
        i_ker_valid <= 1'b1;
        i_ker_last  <= (r == rows - 1);
        i_ker_row   <= ker_q[base + r];
      end
      else
      begin
        i_img_valid <= 1'b1;
        i_img_last  <= (r == rows - 1);
        i_img_row   <= img_q[base + r];
      end
      @(negedge clk);
      while (!(kernel ? o_ker_ready : o_img_ready))
        @(negedge clk);
      @(posedge clk);   // Row taken on this edge
    end
    i_img_valid <= 1'b0;
    i_img_last  <= 1'b0;
    i_ker_valid <= 1'b0;
    i_ker_last  <= 1'b0;
  endtask

  task automatic receive_output(int t);
    int       got;
    out_row_t exp_row;
    logic     exp_last;
    got = 0;
    while (got < out_rows_q[t])
    begin
      i_out_ready <= (((next_random() >> 16) % 4) != 0);
      @(negedge clk);
      if (o_out_valid && i_out_ready)
      begin
        exp_row  = exp_q[exp_base[t] + got];
        exp_last = (got == out_rows_q[t] - 1);
        if (o_out_row !== exp_row)
        begin
          $display("error: o_out_row test %0d row %0d expected %h got %h",
                   t, got, exp_row, o_out_row);
          value_errs++;
        end
        if (o_out_last !== exp_last)
        begin
          $display("error: o_out_last test %0d row %0d expected %h got %h",
                   t, got, exp_last, o_out_last);
          value_errs++;
        end
        rows_checked++;
        got++;
      end
      @(posedge clk);
    end
    i_out_ready <= 1'b1;
    @(negedge clk);
    while (!o_done)
    begin
      if (o_out_valid)
      begin
        $display("an extra output row appeared in test %0d", t);
        proto_errs++;
      end
      @(negedge clk);
    end
    @(posedge clk);
    i_out_ready <= 1'b0;
  endtask

  // Instruction ready and done pulse protocol
  always @(negedge clk)
  begin
    if (rstnn)
    begin
      if (o_done)
      begin
        done_count++;
        if (!op_active)
        begin
          $display("o_done pulsed with no operation in progress");
          proto_errs++;
        end
        op_active = 1'b0;
      end
      else if (op_active && o_inst_ready)
      begin
        $display("o_inst_ready went high before o_done");
        proto_errs++;
      end
      if (i_inst_valid && o_inst_ready)
        op_active = 1'b1;
    end
  end

  initial
  begin
    rstnn        = 1'b0;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    i_img_valid  = 1'b0;
    i_img_last   = 1'b0;
    i_img_row    = '0;
    i_ker_valid  = 1'b0;
    i_ker_last   = 1'b0;
    i_ker_row    = '0;
    i_out_ready  = 1'b0;
    value_errs   = 0;
    proto_errs   = 0;
    rows_checked = 0;
    done_count   = 0;
    op_active    = 1'b0;
    tests_loaded = 1'b0;
    rng          = 32'd98;
    load_tests();
    n_tests      = inst_q.size();
    tests_loaded = 1'b1;
    repeat (2) @(posedge clk);
    rstnn <= 1'b1;
    @(negedge clk);
    if (o_inst_ready !== 1'b1)
    begin
      $display("error: o_inst_ready after reset expected %h got %h", 1'b1, o_inst_ready);
      value_errs++;
    end
    if ({o_img_ready, o_ker_ready, o_out_valid, o_done} !== 4'b0000)
    begin
      $display(
        "error: {o_img_ready, o_ker_ready, o_out_valid, o_done} after reset expected %h got %h",
        4'b0000, {o_img_ready, o_ker_ready, o_out_valid, o_done});
      value_errs++;
    end
    for (int t = 0; t < n_tests; t++)
    begin
      send_instruction(t);
      load_matrix(t, 1'b0);
      load_matrix(t, 1'b1);
      receive_output(t);
      if (done_count != t + 1)
      begin
        $display("o_done pulsed %0d times by the end of test %0d", done_count, t);
        proto_errs++;
      end
    end
    if (n_tests == 0)
      $display("no tests were read from the tests file");
    $display("tests: %0d  rows checked: %0d  value errors: %0d  protocol errors: %0d",
             n_tests, rows_checked, value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0 && n_tests > 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Watchdog budget scales with the number of tests
  initial
  begin
    wait (tests_loaded);
    repeat (n_tests * CYCLES_PER_TEST + 10) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles",
             n_tests * CYCLES_PER_TEST + 10);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* sim/conv2d_tests.txt */
# Each test: img_rows_m1 img_cols_m1 ker_rows_m1 ker_cols_m1 stride_m1, then image rows,
# kernel rows and expected output rows; one row per line, element 0 first, all in hex
5 5 2 2 0
02 fd f8 f3 ee e9
05 00 fb f6 f1 ec
08 03 fe f9 f4 ef
0b 06 01 fc f7 f2
0e 09 04 ff fa f5
11 0c 07 02 fd f8
01 fe 03
00 04 ff
fd 02 01
fffe1 fffc8 fffaf fff96
ffff0 fffd7 fffbe fffa5
fffff fffe6 fffcd fffb4
0000e ffff5 fffdc fffc3
4 3 1 2 0
f9 fd 01 05
f7 fb ff 03
f5 f9 fd 01
f3 f7 fb ff
f1 f5 f9 fd
02 ff 00
fd 01 05
00006 00016
ffffe 0000e
ffff6 00006
fffee ffffe
3 5 2 1 1
f6 f7 f8 f9 fa fb
fb fc fd fe ff 00
00 01 02 03 04 05
05 06 07 08 09 0a
ff 02
03 fc
01 01
ffffa ffffe 00002

/* verilog/conv2d_ctrl.sv */
`include "conv2d_defines.svh"

module conv2d_ctrl
  import conv2d_pkg::*;
(
  input  logic clk,
  input  logic rstnn,
  input  logic i_inst_valid,
  output logic o_inst_ready,
  input  logic i_img_full,
  input  logic i_ker_full,
  input  logic i_core_done,
  input  logic i_store_done,
  output logic o_load_en,
  output logic o_core_start,
  output logic o_store_en,
  output logic o_done
);

  ctrl_state_t state;
  logic go_load;
  logic go_exec;
  logic go_store;
  logic go_idle;

  assign go_load  = (state == ST_IDLE)  & i_inst_valid;
  assign go_exec  = (state == ST_LOAD)  & i_img_full & i_ker_full;
  assign go_store = (state == ST_EXEC)  & i_core_done;
  assign go_idle  = (state == ST_STORE) & i_store_done;

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      state        <= ST_IDLE;
      o_core_start <= 1'b0;
      o_done       <= 1'b0;
    end
    else
    begin
      if (go_load)
        state <= ST_LOAD;
      else if (go_exec)
        state <= ST_EXEC;
      else if (go_store)
        state <= ST_STORE;
      else if (go_idle)
        state <= ST_IDLE;
      o_core_start <= go_exec;  // First EXEC cycle
      o_done       <= go_idle;  // First IDLE cycle
    end
  end

  assign o_inst_ready = (state == ST_IDLE);
  assign o_load_en    = (state == ST_LOAD);   // Falling edge clears the loaders
  assign o_store_en   = (state == ST_STORE);

  a_core_done_in_exec: assert property (@(posedge clk) disable iff (!rstnn)
    i_core_done |-> (state == ST_EXEC));

endmodule

/* verilog/conv2d_defines.svh */
`ifndef CONV2D_DEFINES_SVH
`define CONV2D_DEFINES_SVH

// Element widths
`define CONV_SCALAR_W 8   // Image and kernel element
`define CONV_ACC_W    20  // Output element and accumulator

// Largest matrix dimensions
`define CONV_IMG_MAX 6
`define CONV_KER_MAX 3
`define CONV_OUT_MAX 4

// Dimension field holds size minus one
`define CONV_DIM_W 3

`endif

/* verilog/conv2d_inst_reg.sv */
`include "conv2d_defines.svh"

module conv2d_inst_reg
  import conv2d_pkg::*;
(
  input  logic        clk,
  input  logic        rstnn,
  input  logic        i_load,
  input  conv_inst_t  i_inst,
  output conv_shape_t o_shape
);

  dim_t out_rows_m1;
  dim_t out_cols_m1;

  // Output size minus one is (image - kernel) / stride
  always_comb
  begin
    out_rows_m1 = (i_inst.img_rows_m1 - i_inst.ker_rows_m1) >> i_inst.stride_m1;
    out_cols_m1 = (i_inst.img_cols_m1 - i_inst.ker_cols_m1) >> i_inst.stride_m1;
  end

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
      o_shape <= '0;
    else if (i_load)
    begin
      o_shape.inst        <= i_inst;
      o_shape.out_rows_m1 <= out_rows_m1;
      o_shape.out_cols_m1 <= out_cols_m1;
    end
  end

  // Captured shape keeps the kernel inside the image and the output within limits
  property p_kernel_fits;
    @(posedge clk) disable iff (!rstnn)
      i_load |=> (o_shape.inst.ker_rows_m1 <= o_shape.inst.img_rows_m1) &&
                 (o_shape.inst.ker_cols_m1 <= o_shape.inst.img_cols_m1) &&
                 (o_shape.out_rows_m1 < dim_t'(`CONV_OUT_MAX)) &&
                 (o_shape.out_cols_m1 < dim_t'(`CONV_OUT_MAX));
  endproperty
  a_kernel_fits: assert property (p_kernel_fits);

endmodule

/* verilog/conv2d_mac_core.sv */
`include "conv2d_defines.svh"

module conv2d_mac_core
  import conv2d_pkg::*;
(
  input  logic                                                clk,
  input  logic                                                rstnn,
  input  logic                                                i_start,
  input  conv_shape_t                                         i_shape,
  input  scalar_t [`CONV_IMG_MAX-1:0][`CONV_IMG_MAX-1:0]      i_img,
  input  scalar_t [`CONV_KER_MAX-1:0][`CONV_KER_MAX-1:0]      i_ker,
  output logic                                                o_wr_valid,
  output out_wr_t                                             o_wr,
  output logic                                                o_done
);

  localparam int IDX_W = `CONV_DIM_W + 1;

  dim_t orow;
  dim_t ocol;
  dim_t krow;
  dim_t kcol;
  logic busy;
  logic wr_phase;   // One cycle per element to hand it to the store
  acc_t acc;
  logic [IDX_W-1:0] img_r;
  logic [IDX_W-1:0] img_c;
  scalar_t img_px;
  scalar_t ker_px;
  logic signed [2*`CONV_SCALAR_W-1:0] prod;
  logic last_tap;
  logic last_elem;

  //////////////////////////////////////////////////
  // Tap addressing
  //////////////////////////////////////////////////

  // Image position is out * stride + kernel offset
  assign img_r = ({1'b0, orow} << i_shape.inst.stride_m1) + {1'b0, krow};
  assign img_c = ({1'b0, ocol} << i_shape.inst.stride_m1) + {1'b0, kcol};

  assign img_px = i_img[img_r][img_c];
  assign ker_px = i_ker[krow][kcol];
  assign prod   = img_px * ker_px;

  assign last_tap  = (krow == i_shape.inst.ker_rows_m1) && (kcol == i_shape.inst.ker_cols_m1);
  assign last_elem = (orow == i_shape.out_rows_m1) && (ocol == i_shape.out_cols_m1);

  //////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      busy     <= 1'b0;
      wr_phase <= 1'b0;
      orow     <= '0;
      ocol     <= '0;
      krow     <= '0;
      kcol     <= '0;
      o_done   <= 1'b0;
    end
    else
    begin
      o_done <= 1'b0;
      if (i_start)
      begin
        busy     <= 1'b1;
        wr_phase <= 1'b0;
        orow     <= '0;
        ocol     <= '0;
        krow     <= '0;
        kcol     <= '0;
      end
      else if (busy && !wr_phase)
      begin
        if (last_tap)
        begin
          wr_phase <= 1'b1;
          krow     <= '0;
          kcol     <= '0;
        end
        else if (kcol == i_shape.inst.ker_cols_m1)
        begin
          kcol <= '0;
          krow <= krow + 1'b1;
        end
        else
          kcol <= kcol + 1'b1;
      end
      else if (busy)
      begin
        wr_phase <= 1'b0;
        if (last_elem)
        begin
          busy   <= 1'b0;
          o_done <= 1'b1;   // After the final element
        end
        else if (ocol == i_shape.out_cols_m1)
        begin
          ocol <= '0;
          orow <= orow + 1'b1;
        end
        else
          ocol <= ocol + 1'b1;
      end
    end
  end

  // Accumulator cleared at start and after each write
  always_ff @(posedge clk)
  begin
    if (i_start || (busy && wr_phase))
      acc <= '0;
    else if (busy)
      acc <= acc + acc_t'(prod);
  end

  assign o_wr_valid = busy & wr_phase;
  assign o_wr       = '{row: orow, col: ocol, value: acc};

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rstnn)
    i_start |-> !busy);

endmodule

/* verilog/conv2d_matrix_loader.sv */
`include "conv2d_defines.svh"

module conv2d_matrix_loader
  import conv2d_pkg::*;
#(
  parameter int MAX_ROWS = 6,
  parameter int MAX_COLS = 6
)
(
  input  logic                                   clk,
  input  logic                                   rstnn,
  input  logic                                   i_en,
  input  logic                                   i_valid,
  input  logic                                   i_last,
  input  scalar_t [MAX_COLS-1:0]                 i_row,
  output logic                                   o_ready,
  output logic                                   o_full,
  output scalar_t [MAX_ROWS-1:0][MAX_COLS-1:0]   o_matrix
);

  localparam int CNT_W = $clog2(MAX_ROWS + 1);

  logic [CNT_W-1:0] row_cnt;
  logic             accept;

  assign o_ready = i_en & ~o_full;
  assign accept  = i_valid & o_ready;

  //////////////////////////////////////////////////
  // Row counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      row_cnt <= '0;
      o_full  <= 1'b0;
    end
    else if (!i_en)
    begin
      // Rearm for the next operation
      row_cnt <= '0;
      o_full  <= 1'b0;
    end
    else if (accept)
    begin
      row_cnt <= row_cnt + 1'b1;
      o_full  <= i_last;
    end
  end

  // Matrix buffer filled from row 0
  always_ff @(posedge clk)
  begin
    if (accept)
      o_matrix[row_cnt] <= i_row;
  end

  a_row_in_range: assert property (@(posedge clk) disable iff (!rstnn)
    accept |-> (row_cnt < CNT_W'(MAX_ROWS)));

endmodule

/* verilog/conv2d_output_store.sv */
`include "conv2d_defines.svh"

module conv2d_output_store
  import conv2d_pkg::*;
(
  input  logic        clk,
  input  logic        rstnn,
  input  logic        i_wr_valid,
  input  out_wr_t     i_wr,
  input  logic        i_en,
  input  conv_shape_t i_shape,
  output logic        o_valid,
  output logic        o_last,
  output out_row_t    o_row,
  input  logic        i_ready,
  output logic        o_done
);

  acc_t [`CONV_OUT_MAX-1:0][`CONV_OUT_MAX-1:0] out_buf;
  dim_t rd_row;

  assign o_valid = i_en;                                  // From the first STORE cycle
  assign o_last  = (rd_row == i_shape.out_rows_m1);
  assign o_done  = o_valid & i_ready & o_last;            // Last row handshake

  // Unused columns go out as zero
  always_comb
  begin
    for (int c = 0; c < `CONV_OUT_MAX; c++)
    begin
      if (dim_t'(c) <= i_shape.out_cols_m1)
        o_row[c*`CONV_ACC_W +: `CONV_ACC_W] = out_buf[rd_row][c];
      else
        o_row[c*`CONV_ACC_W +: `CONV_ACC_W] = '0;
    end
  end

  //////////////////////////////////////////////////
  // Output buffer and row pointer
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (o_done)
      out_buf <= '0;    // Nothing carries into the next operation
    else if (i_wr_valid)
      out_buf[i_wr.row][i_wr.col] <= i_wr.value;
  end

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
      rd_row <= '0;
    else if (o_done)
      rd_row <= '0;
    else if (o_valid && i_ready)
      rd_row <= rd_row + 1'b1;
  end

  // Row held steady under back-pressure
  a_hold_row: assert property (@(posedge clk) disable iff (!rstnn)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_row)));

endmodule

/* verilog/conv2d_pkg.sv */
`include "conv2d_defines.svh"

package conv2d_pkg;

  typedef logic signed [`CONV_SCALAR_W-1:0] scalar_t;
  typedef logic signed [`CONV_ACC_W-1:0]    acc_t;
  typedef logic [`CONV_DIM_W-1:0]           dim_t;

  // Element 0 in the low bits
  typedef logic [`CONV_IMG_MAX*`CONV_SCALAR_W-1:0] img_row_t;
  typedef logic [`CONV_KER_MAX*`CONV_SCALAR_W-1:0] ker_row_t;
  typedef logic [`CONV_OUT_MAX*`CONV_ACC_W-1:0]    out_row_t;

  typedef struct packed {
    dim_t img_rows_m1;
    dim_t img_cols_m1;
    dim_t ker_rows_m1;
    dim_t ker_cols_m1;
    logic stride_m1;    // 0 for stride 1, 1 for stride 2
  } conv_inst_t;

  typedef struct packed {
    conv_inst_t inst;
    dim_t       out_rows_m1;
    dim_t       out_cols_m1;
  } conv_shape_t;

  // One output element write
  typedef struct packed {
    dim_t row;
    dim_t col;
    acc_t value;
  } out_wr_t;

  typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_EXEC, ST_STORE} ctrl_state_t;

endpackage

/* verilog/conv2d_top.sv */
`include "conv2d_defines.svh"

module conv2d_top
  import conv2d_pkg::*;
(
  input  logic       clk,
  input  logic       rstnn,
  input  logic       i_inst_valid,
  input  conv_inst_t i_inst,
  output logic       o_inst_ready,
  input  logic       i_img_valid,
  input  logic       i_img_last,
  input  img_row_t   i_img_row,
  output logic       o_img_ready,
  input  logic       i_ker_valid,
  input  logic       i_ker_last,
  input  ker_row_t   i_ker_row,
  output logic       o_ker_ready,
  output logic       o_out_valid,
  output logic       o_out_last,
  output out_row_t   o_out_row,
  input  logic       i_out_ready,
  output logic       o_done
);

  logic        inst_load;
  conv_shape_t shape;
  logic        img_full;
  logic        ker_full;
  logic        load_en;
  logic        core_start;
  logic        core_done;
  logic        store_en;
  logic        store_done;
  logic        wr_valid;
  out_wr_t     wr;
  scalar_t [`CONV_IMG_MAX-1:0][`CONV_IMG_MAX-1:0] img_matrix;
  scalar_t [`CONV_KER_MAX-1:0][`CONV_KER_MAX-1:0] ker_matrix;

  assign inst_load = i_inst_valid & o_inst_ready;   // Instruction handshake

  conv2d_inst_reg u_inst_reg
  (
    .clk     (clk),
    .rstnn   (rstnn),
    .i_load  (inst_load),
    .i_inst  (i_inst),
    .o_shape (shape)
  );

  conv2d_ctrl u_ctrl
  (
    .clk          (clk),
    .rstnn        (rstnn),
    .i_inst_valid (i_inst_valid),
    .o_inst_ready (o_inst_ready),
    .i_img_full   (img_full),
    .i_ker_full   (ker_full),
    .i_core_done  (core_done),
    .i_store_done (store_done),
    .o_load_en    (load_en),
    .o_core_start (core_start),
    .o_store_en   (store_en),
    .o_done       (o_done)
  );

  conv2d_matrix_loader #(.MAX_ROWS(`CONV_IMG_MAX), .MAX_COLS(`CONV_IMG_MAX)) u_img_loader
  (
    .clk      (clk),
    .rstnn    (rstnn),
    .i_en     (load_en),
    .i_valid  (i_img_valid),
    .i_last   (i_img_last),
    .i_row    (i_img_row),
    .o_ready  (o_img_ready),
    .o_full   (img_full),
    .o_matrix (img_matrix)
  );

  conv2d_matrix_loader #(.MAX_ROWS(`CONV_KER_MAX), .MAX_COLS(`CONV_KER_MAX)) u_ker_loader
  (
    .clk      (clk),
    .rstnn    (rstnn),
    .i_en     (load_en),
    .i_valid  (i_ker_valid),
    .i_last   (i_ker_last),
    .i_row    (i_ker_row),
    .o_ready  (o_ker_ready),
    .o_full   (ker_full),
    .o_matrix (ker_matrix)
  );

  conv2d_mac_core u_mac_core
  (
    .clk        (clk),
    .rstnn      (rstnn),
    .i_start    (core_start),
    .i_shape    (shape),
    .i_img      (img_matrix),
    .i_ker      (ker_matrix),
    .o_wr_valid (wr_valid),
    .o_wr       (wr),
    .o_done     (core_done)
  );

  conv2d_output_store u_output_store
  (
    .clk        (clk),
    .rstnn      (rstnn),
    .i_wr_valid (wr_valid),
    .i_wr       (wr),
    .i_en       (store_en),
    .i_shape    (shape),
    .o_valid    (o_out_valid),
    .o_last     (o_out_last),
    .o_row      (o_out_row),
    .i_ready    (i_out_ready),
    .o_done     (store_done)
  );

endmodule
